/* all.f */
anim_pkg.sv
anim_limit_table.sv
anim_decode.sv
frame_sequencer.sv
segment_render.sv
anim_player_top.sv
tb_anim_player.sv

/* anim_decode.sv */
`default_nettype none

module anim_decode (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         sel,       // one cycle load strobe
    input  wire  [anim_pkg::ANIM_W-1:0] anim_sel,  // sampled with sel
    output anim_pkg::anim_cmd_t         cmd
);
    import anim_pkg::*;

    logic [LIMIT_W-1:0] tbl_limit;  // count of the animation on anim_sel
    anim_class_t        nxt_class;  // class of that animation

    anim_limit_table i_anim_limit_table (
        .animation (anim_sel),
        .limit     (tbl_limit)
    );

    // class rule, counter wins over the count based classes
    always_comb begin
        if (anim_sel == COUNT_ANIM) begin
            nxt_class = class_count;
        end else if (tbl_limit == SPIN_LIMIT_A || tbl_limit == SPIN_LIMIT_B) begin
            nxt_class = class_spin;
        end else if (tbl_limit == BLINK_LIMIT) begin
            nxt_class = class_blink;
        end else begin
            nxt_class = class_binary;  // random ones land here too
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd.anim    <= COUNT_ANIM;   // counter from power-up
            cmd.limit   <= RESET_LIMIT;
            cmd.pclass  <= class_count;
            cmd.restart <= 1'b0;         // no restart pulse out of reset
        end else begin
            cmd.restart <= sel;          // high only the cycle after sel
            if (sel) begin
                cmd.anim   <= anim_sel;
                cmd.limit  <= tbl_limit;
                cmd.pclass <= nxt_class;
            end
        end
    end

    // sel is a strobe, so restart must drop after one cycle
    a_restart_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd.restart |=> !cmd.restart
    ) else $error("restart high for more than one cycle");

endmodule

`default_nettype wire

/* anim_limit_table.sv */
`default_nettype none

module anim_limit_table (
    input  wire  [anim_pkg::ANIM_W-1:0]  animation,
    output logic [anim_pkg::LIMIT_W-1:0] limit
);
    import anim_pkg::*;

    // frames per animation, pure lookup
    always_comb begin
        case (animation)
            6'd0:    limit = 6'd10;  // decimal counter 0..9
            6'd1:    limit = 6'd12;  // twelve step sequence
            6'd2:    limit = 6'd6;   // ring cw
            6'd3:    limit = 6'd6;   // ring ccw
            6'd4:    limit = 6'd6;   // pair ring ccw
            6'd5:    limit = 6'd6;   // pair ring cw
            6'd6:    limit = 6'd6;   // pair swap
            6'd7:    limit = 6'd2;   // up/down boxed
            6'd8:    limit = 6'd4;   // up/down straight
            6'd9:    limit = 6'd4;
            6'd10:   limit = 6'd2;   // plain blink
            6'd11:   limit = 6'd2;   // low box vs high box
            6'd12:   limit = 6'd2;   // right vs left half
            6'd13:   limit = 6'd2;
            6'd14:   limit = 6'd2;
            6'd15:   limit = 6'd4;   // circle downward
            6'd16:   limit = 6'd6;   // greeting letters
            6'd17:   limit = 6'd2;   // diagonal flip
            6'd18:   limit = 6'd7;   // random set, 7 frames
            6'd19:   limit = 6'd7;
            6'd20:   limit = 6'd7;
            6'd21:   limit = 6'd7;
            6'd22:   limit = 6'd7;
            6'd23:   limit = 6'd4;   // circle upward
            6'd24:   limit = 6'd16;  // longer random set
            6'd25:   limit = 6'd16;
            6'd26:   limit = 6'd16;
            6'd27:   limit = 6'd16;  // random digits
            6'd28:   limit = 6'd32;  // random digits, long
            6'd29:   limit = 6'd5;   // pulse
            6'd30:   limit = 6'd11;  // greeting message
            6'd31:   limit = 6'd32;  // longest random
            // upper half of the table, mostly filler counts
            6'd32:   limit = 6'd5;   // pulse again
            6'd33:   limit = 6'd9;
            6'd34:   limit = 6'd5;
            6'd35:   limit = 6'd5;
            6'd36:   limit = 6'd5;
            6'd37:   limit = 6'd5;
            6'd38:   limit = 6'd5;
            6'd39:   limit = 6'd5;
            6'd40:   limit = 6'd5;
            6'd41:   limit = 6'd5;
            6'd42:   limit = 6'd5;
            6'd43:   limit = 6'd5;
            6'd44:   limit = 6'd5;
            6'd45:   limit = 6'd5;
            6'd46:   limit = 6'd5;
            6'd47:   limit = 6'd5;
            6'd48:   limit = 6'd5;
            6'd49:   limit = 6'd5;
            6'd50:   limit = 6'd5;   // last 5 frame slot
            6'd51:   limit = 6'd2;   // two frame slots to the end
            6'd52:   limit = 6'd2;
            6'd53:   limit = 6'd2;
            6'd54:   limit = 6'd2;
            6'd55:   limit = 6'd2;
            6'd56:   limit = 6'd2;
            6'd57:   limit = 6'd2;
            6'd58:   limit = 6'd2;
            6'd59:   limit = 6'd2;
            6'd60:   limit = 6'd2;
            6'd61:   limit = 6'd2;
            6'd62:   limit = 6'd2;
            6'd63:   limit = 6'd2;
            default: limit = DEFAULT_LIMIT;  // x on the select lines
        endcase
    end

endmodule

`default_nettype wire

/* anim_patterns.txt */
# animation number, expected frame count, expected class code
# class codes 0 count, 1 spin, 2 blink, 3 binary
0 10 0
1 12 3
2 6 1
3 6 1
4 6 1
5 6 1
6 6 1
7 2 2
8 4 1
9 4 1
10 2 2
11 2 2
12 2 2
13 2 2
14 2 2
15 4 1
16 6 1
17 2 2
18 7 3
19 7 3
20 7 3
21 7 3
22 7 3
23 4 1
24 16 3
25 16 3
26 16 3
27 16 3
28 32 3
29 5 3
30 11 3
31 32 3
32 5 3
33 9 3
34 5 3
35 5 3
36 5 3
37 5 3
38 5 3
39 5 3
40 5 3
41 5 3
42 5 3
43 5 3
44 5 3
45 5 3
46 5 3
47 5 3
48 5 3
49 5 3
50 5 3
51 2 2
52 2 2
53 2 2
54 2 2
55 2 2
56 2 2
57 2 2
58 2 2
59 2 2
60 2 2
61 2 2
62 2 2
63 2 2

/* anim_pkg.sv */
`default_nettype none

package anim_pkg;

    localparam int ANIM_W   = 6;                 // animation number width
    localparam int LIMIT_W  = 6;                 // frame count width, largest count 32
    localparam int TICK_DIV = 8;                 // clocks per frame step, short for sim
    localparam int TICK_W   = $clog2(TICK_DIV);  // tick divider counter width
    localparam int SEG_W    = 7;                 // segments a..g, bit 0 is a

    // frame counts with a fixed meaning in the decode and table
    localparam logic [LIMIT_W-1:0] DEFAULT_LIMIT = 6'd32;  // table fallback
    localparam logic [LIMIT_W-1:0] RESET_LIMIT   = 6'd10;  // counter runs from power-up
    localparam logic [LIMIT_W-1:0] SPIN_LIMIT_A  = 6'd4;   // short spin
    localparam logic [LIMIT_W-1:0] SPIN_LIMIT_B  = 6'd6;   // full ring spin
    localparam logic [LIMIT_W-1:0] BLINK_LIMIT   = 6'd2;   // on/off pair

    localparam logic [ANIM_W-1:0] COUNT_ANIM = '0;  // decimal counter animation

    localparam logic [SEG_W-1:0] SEG_ALL_ON = '1;   // every segment lit
    localparam logic [SEG_W-1:0] SEG_OFF    = '0;   // blank digit

    // render rule picked by the decode stage
    typedef enum logic [1:0] {
        class_count  = 2'd0,  // decimal glyph
        class_spin   = 2'd1,  // single lit segment walking
        class_blink  = 2'd2,  // all on then all off
        class_binary = 2'd3   // raw frame bits
    } anim_class_t;

    // decode -> sequencer/render, 15 bits
    typedef struct packed {
        logic [ANIM_W-1:0]  anim;     // selected animation
        logic [LIMIT_W-1:0] limit;    // frames in this animation
        anim_class_t        pclass;   // render class
        logic               restart;  // one cycle on new selection
    } anim_cmd_t;

    // sequencer -> render, 9 bits
    typedef struct packed {
        logic [LIMIT_W-1:0] frame;   // current frame, below limit
        anim_class_t        pclass;  // class aligned with frame
        logic               valid;   // low only right after reset
    } frame_state_t;

endpackage

`default_nettype wire

/* anim_player_top.sv */
`default_nettype none

module anim_player_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          sel,       // load strobe
    input  wire  [anim_pkg::ANIM_W-1:0]  anim_sel,  // animation to load
    output logic [anim_pkg::SEG_W-1:0]   seg,       // segment drive a..g
    output logic [anim_pkg::LIMIT_W-1:0] frame,     // current frame
    output logic [anim_pkg::LIMIT_W-1:0] limit      // frames in animation
);
    import anim_pkg::*;

    anim_cmd_t    cmd;     // decode stage result
    frame_state_t fstate;  // sequencer state

    // decode stage
    anim_decode i_anim_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .sel      (sel),
        .anim_sel (anim_sel),
        .cmd      (cmd)
    );

    // execute stage
    frame_sequencer i_frame_sequencer (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd    (cmd),
        .fstate (fstate)
    );

    // result stage
    segment_render i_segment_render (
        .clk    (clk),
        .rst_n  (rst_n),
        .fstate (fstate),
        .seg    (seg)
    );

    assign frame = fstate.frame;  // observation taps
    assign limit = cmd.limit;

endmodule

`default_nettype wire

/* frame_sequencer.sv */
`default_nettype none

module frame_sequencer (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire anim_pkg::anim_cmd_t cmd,     // limit, class and restart
    output anim_pkg::frame_state_t  fstate
);
    import anim_pkg::*;

    logic [TICK_W-1:0] tick_cnt;  // clocks inside the current frame
    logic              tick;      // last clock of the frame
    logic              last_frame; // frame at limit-1, wrap next

    assign tick       = (tick_cnt == TICK_W'(TICK_DIV - 1));
    assign last_frame = (fstate.frame >= cmd.limit - 1'b1);  // >= guards a stale frame

    // tick divider
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (cmd.restart || tick) begin
            tick_cnt <= '0;               // new frame period starts
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // frame counter, valid and class alignment
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fstate.frame  <= '0;
            fstate.pclass <= class_count;  // matches reset cmd
            fstate.valid  <= 1'b0;
        end else begin
            fstate.valid  <= 1'b1;         // one cycle after reset release
            fstate.pclass <= cmd.pclass;   // lands with frame 0 after a load
            if (cmd.restart) begin
                fstate.frame <= '0;        // preempts whatever was running
            end else if (tick) begin
                if (last_frame) begin
                    fstate.frame <= '0;    // wrap
                end else begin
                    fstate.frame <= fstate.frame + 1'b1;
                end
            end
        end
    end

    // frame stays inside the animation, except the cycle where
    // a new smaller limit has arrived and the restart is pending
    a_frame_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fstate.valid && !cmd.restart) |-> (fstate.frame < cmd.limit)
    ) else $error("frame %0d not below limit %0d", fstate.frame, cmd.limit);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the animation player testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tb_anim_player -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* segment_render.sv */
`default_nettype none

module segment_render (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire anim_pkg::frame_state_t  fstate,  // frame and class
    output logic [anim_pkg::SEG_W-1:0]   seg      // active high, bit 0 is a
);
    import anim_pkg::*;

    logic [SEG_W-1:0] nxt_seg;  // pattern for the current frame

    // standard digit glyphs, g is bit 6
    function automatic logic [SEG_W-1:0] digit_glyph(input logic [LIMIT_W-1:0] digit);
        case (digit)
            6'd0:    digit_glyph = 7'h3f;
            6'd1:    digit_glyph = 7'h06;  // b c
            6'd2:    digit_glyph = 7'h5b;
            6'd3:    digit_glyph = 7'h4f;
            6'd4:    digit_glyph = 7'h66;
            6'd5:    digit_glyph = 7'h6d;
            6'd6:    digit_glyph = 7'h7d;
            6'd7:    digit_glyph = 7'h07;  // a b c
            6'd8:    digit_glyph = 7'h7f;
            6'd9:    digit_glyph = 7'h6f;
            default: digit_glyph = SEG_OFF;  // not a decimal digit
        endcase
    endfunction

    always_comb begin
        case (fstate.pclass)
            class_count: begin
                nxt_seg = digit_glyph(fstate.frame);
            end
            class_spin: begin
                nxt_seg = SEG_W'(1) << fstate.frame;  // frame 0..5 walks a..f
            end
            class_blink: begin
                nxt_seg = fstate.frame[0] ? SEG_OFF : SEG_ALL_ON;  // even on, odd off
            end
            default: begin
                nxt_seg = SEG_W'(fstate.frame);  // binary, g stays off
            end
        endcase
    end

    // output register, blank until the sequencer is valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seg <= SEG_OFF;
        end else if (fstate.valid) begin
            seg <= nxt_seg;
        end else begin
            seg <= SEG_OFF;
        end
    end

    // a spin frame always shows a single segment one cycle later
    a_spin_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fstate.valid && fstate.pclass == class_spin) |=> $onehot(seg)
    ) else $error("spin pattern %b not one-hot", seg);

endmodule

`default_nettype wire

/* tb_anim_player.sv */
`default_nettype none

module tb_anim_player;
    timeunit 1ns;
    timeprecision 1ps;

    import anim_pkg::*;

    logic               clk;
    logic               rst_n;
    logic               sel;
    logic [ANIM_W-1:0]  anim_sel;
    logic [SEG_W-1:0]   seg;
    logic [LIMIT_W-1:0] frame;
    logic [LIMIT_W-1:0] limit;

    int          errors;      // wrong values seen
    int          timeouts;    // waits that ran out
    logic [31:0] lfsr;        // random source for frame counts and reselects
    int          anims[$];    // animation numbers from the pattern file
    int          lims[$];     // expected frame counts
    int          clss[$];     // expected class codes

    anim_player_top i_anim_player_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .sel      (sel),
        .anim_sel (anim_sel),
        .seg      (seg),
        .frame    (frame),
        .limit    (limit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // segment pattern from the render rules, bit order gfedcba
    function automatic logic [SEG_W-1:0] expected_seg(input int cls, input int fr);
        logic [SEG_W-1:0] glyphs [10];
        glyphs = '{7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111, 7'b1100110,
                   7'b1101101, 7'b1111101, 7'b0000111, 7'b1111111, 7'b1101111};
        if (cls == int'(class_count)) begin
            expected_seg = (fr < 10) ? glyphs[fr] : 7'b0000000;
        end else if (cls == int'(class_spin)) begin
            expected_seg = 7'(1) << fr;           // one segment, a first
        end else if (cls == int'(class_blink)) begin
            expected_seg = (fr % 2 == 0) ? 7'b1111111 : 7'b0000000;
        end else begin
            expected_seg = {1'b0, 6'(fr)};        // g dark
        end
    endfunction

    task automatic check_value(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("[ERROR] %0d ns: %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_seg(input logic [SEG_W-1:0] exp);
        if (seg !== exp) begin
            $display("[ERROR] %0d ns: seg expected %b got %b", $time, exp, seg);
            errors++;
        end
    endtask

    // follows n frame steps, checks order, step spacing and glyphs
    task automatic watch_frames(input int n, input int lim, input int cls,
                                input int start_wait);
        int seen;
        int waited;
        int prev;
        int fr;
        bit seg_due;
        bit stop;
        seen    = 0;
        waited  = start_wait;
        prev    = int'(frame);
        seg_due = 1'b1;          // seg lags frame by one cycle
        stop    = 1'b0;
        while (!stop && (seen < n || seg_due)) begin
            @(negedge clk);
            waited++;
            fr = int'(frame);
            if (seg_due) begin
                check_seg(expected_seg(cls, prev));
                seg_due = 1'b0;
            end
            if (fr >= lim) begin
                $display("[ERROR] %0d ns: frame expected below %0d got %0d", $time, lim, fr);
                errors++;
            end
            if (fr != prev) begin
                check_value("frame", (prev + 1) % lim, fr);
                check_value("frame step cycles", TICK_DIV, waited);
                prev    = fr;
                waited  = 0;
                seen++;
                seg_due = 1'b1;
            end else if (waited > TICK_DIV + 2) begin
                $display("timeout: frame stuck at %0d for %0d cycles", fr, waited);
                timeouts++;
                stop = 1'b1;
            end
        end
    endtask

    // strobe sel for one cycle, frame 0 two cycles later
    task automatic select_anim(input int a, input int lim, input int mid);
        sel      = 1'b1;
        anim_sel = 6'(a);
        @(negedge clk);
        sel = 1'b0;
        @(negedge clk);
        check_value("limit", lim, int'(limit));
        if (mid != 0) begin
            check_value("frame after preempt", 0, int'(frame));
        end else begin
            check_value("frame", 0, int'(frame));
        end
    endtask

    initial begin
        int    fd;
        int    a;
        int    l;
        int    c;
        int    n;
        int    nfr;
        int    mid;
        string line;
        errors   = 0;
        timeouts = 0;
        lfsr     = 32'h33b4;
        rst_n    = 1'b0;
        sel      = 1'b0;
        anim_sel = '0;

        fd = $fopen("anim_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open anim_patterns.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d", a, l, c);
                    if (n == 3) begin
                        anims.push_back(a);
                        lims.push_back(l);
                        clss.push_back(c);
                    end
                end
            end
            $fclose(fd);
        end
        if (anims.size() != 64) begin
            $display("pattern file holds %0d cases instead of 64", anims.size());
            errors++;
        end

        repeat (3) begin
            @(negedge clk);
            check_seg(7'b0000000);  // dark during reset
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_value("limit", 10, int'(limit));
        check_value("frame", 0, int'(frame));
        check_seg(7'b0000000);      // valid still low here
        watch_frames(12, 10, int'(class_count), 1);  // runs past the 9 to 0 wrap

        foreach (anims[i]) begin
            draw_bits(4, nfr);
            nfr++;                   // 1..16 frames
            draw_bits(1, mid);
            if (mid != 0) begin
                repeat (3) @(negedge clk);  // land inside a frame
            end
            select_anim(anims[i], lims[i], mid);
            watch_frames(nfr, lims[i], clss[i], 0);
        end

        $display("errors %0d timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
